// ==== src/array_geom_pkg.sv ====
package array_geom_pkg;

  // transducer grid. Positions are derived from the index, row by row.
  localparam int NumTrans   = 8;
  localparam int TransWidth = $clog2(NumTrans);
  localparam int GridCols   = 4;  // transducers per row.
  localparam int Pitch      = 10;  // grid spacing in distance units.

  // focus coordinates are signed, transducers sit in the z = 0 plane.
  localparam int CoordWidth = 10;

  // focus store layout, one entry per slot of a sequence point.
  localparam int NumFociMax = 4;
  localparam int NumPoints  = 16;
  localparam int PointWidth = $clog2(NumPoints);
  localparam int SlotWidth  = $clog2(NumFociMax);
  localparam int LevelWidth = 8;  // intensity in slot 0, phase offset elsewhere.

  // the square root of three squared 11-bit differences fits in 11 bits.
  localparam int DistWidth = 11;

endpackage

// ==== src/phase_math_pkg.sv ====
package phase_math_pkg;

  // a full turn of phase is 256 steps.
  localparam int PhaseWidth = 8;
  localparam int ScaleWidth = 8;  // phase steps per distance unit.

  // signed trig samples and their sum over all focus slots.
  localparam int TrigWidth = 8;
  localparam int SumWidth  = 10;

  // stage latencies along the datapath, in cycles.
  localparam int CalcLatency   = 15;
  localparam int LutLatency    = 1;
  localparam int TreeLatency   = 2;
  localparam int CordicLatency = 9;

  // one extra cycle registers the transducer position at issue.
  localparam int PipeLatency = 1 + CalcLatency + LutLatency + TreeLatency + CordicLatency;

  // receiver buffer space, granted as credits.
  localparam int CreditMax   = 4;
  localparam int CreditWidth = $clog2(CreditMax + 1);

endpackage

// ==== src/focus_store.sv ====
`timescale 1ns/10ps
module focus_store (
  input  logic                                         CLK,
  input  logic                                         wr_en,
  input  logic        [array_geom_pkg::PointWidth-1:0] wr_point,
  input  logic        [ array_geom_pkg::SlotWidth-1:0] wr_slot,
  input  logic signed [array_geom_pkg::CoordWidth-1:0] wr_x,
  input  logic signed [array_geom_pkg::CoordWidth-1:0] wr_y,
  input  logic signed [array_geom_pkg::CoordWidth-1:0] wr_z,
  input  logic        [array_geom_pkg::LevelWidth-1:0] wr_level,
  input  logic        [array_geom_pkg::PointWidth-1:0] rd_point,
  input  logic        [ array_geom_pkg::SlotWidth-1:0] rd_slot,
  output logic signed [array_geom_pkg::CoordWidth-1:0] rd_x,
  output logic signed [array_geom_pkg::CoordWidth-1:0] rd_y,
  output logic signed [array_geom_pkg::CoordWidth-1:0] rd_z,
  output logic        [array_geom_pkg::LevelWidth-1:0] rd_level
);
  import array_geom_pkg::*;

  localparam int Depth      = NumPoints * NumFociMax;
  localparam int EntryWidth = 3 * CoordWidth + LevelWidth;

  logic [EntryWidth-1:0] mem [Depth];
  logic [EntryWidth-1:0] rd_q;

  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mem[{wr_point, wr_slot}] <= {wr_x, wr_y, wr_z, wr_level};  // slot is the low address part.
    end
    rd_q <= mem[{rd_point, rd_slot}];  // a read during a write returns the old entry.
  end

  assign {rd_x, rd_y, rd_z, rd_level} = rd_q;

endmodule

// ==== src/focus_phase_calc.sv ====
`timescale 1ns/10ps
module focus_phase_calc (
  input  logic                                         CLK,
  input  logic signed [array_geom_pkg::CoordWidth-1:0] focus_x,
  input  logic signed [array_geom_pkg::CoordWidth-1:0] focus_y,
  input  logic signed [array_geom_pkg::CoordWidth-1:0] focus_z,
  input  logic signed [array_geom_pkg::CoordWidth-1:0] trans_x,
  input  logic signed [array_geom_pkg::CoordWidth-1:0] trans_y,
  input  logic        [phase_math_pkg::ScaleWidth-1:0] wave_scale,
  input  logic        [phase_math_pkg::PhaseWidth-1:0] offset,
  output logic        [phase_math_pkg::PhaseWidth-1:0] phase
);
  import array_geom_pkg::*;
  import phase_math_pkg::*;

  localparam int DiffWidth  = CoordWidth + 1;
  localparam int RadWidth   = 2 * DistWidth;
  localparam int RemWidth   = DistWidth + 3;
  localparam int SqrtStages = DistWidth;  // one root bit per stage.
  localparam int SideWidth  = ScaleWidth + PhaseWidth;

  logic signed [DiffWidth-1:0] dx, dy, dz;
  logic        [ RadWidth-1:0] sq_x, sq_y, sq_z;
  logic        [ RadWidth-1:0] rad_q  [SqrtStages];
  logic        [ RemWidth-1:0] rem_q  [SqrtStages];
  logic        [DistWidth-1:0] root_q [SqrtStages];
  logic        [SideWidth-1:0] side_q [CalcLatency-1];
  logic       [PhaseWidth-1:0] dist_lo;
  logic       [ScaleWidth-1:0] side_scale;
  logic       [PhaseWidth-1:0] side_off;

  // restoring square root step. Brings down the next radicand bit pair.
  function automatic logic [RemWidth+DistWidth-1:0] sqrt_step(input logic [RemWidth-1:0] rem,
                                                              input logic [DistWidth-1:0] root,
                                                              input logic [1:0] pair);
    logic [RemWidth-1:0] rem_sh;
    logic [RemWidth-1:0] trial;
    rem_sh = {rem[RemWidth-3:0], pair};
    trial  = {1'b0, root, 2'b01};
    if (rem_sh >= trial) begin
      return {rem_sh - trial, root[DistWidth-2:0], 1'b1};
    end
    return {rem_sh, root[DistWidth-2:0], 1'b0};
  endfunction

  always_ff @(posedge CLK) begin
    dx <= DiffWidth'(focus_x) - DiffWidth'(trans_x);
    dy <= DiffWidth'(focus_y) - DiffWidth'(trans_y);
    dz <= DiffWidth'(focus_z);  // the array lies in the z = 0 plane.
    sq_x <= RadWidth'(dx) * RadWidth'(dx);
    sq_y <= RadWidth'(dy) * RadWidth'(dy);
    sq_z <= RadWidth'(dz) * RadWidth'(dz);
    rad_q[0] <= sq_x + sq_y + sq_z;
    {rem_q[0], root_q[0]} <= sqrt_step('0, '0, rad_q[0][RadWidth-1-:2]);
    for (int s = 1; s < SqrtStages; s++) begin
      rad_q[s] <= rad_q[s-1] << 2;
      {rem_q[s], root_q[s]} <= sqrt_step(rem_q[s-1], root_q[s-1], rad_q[s][RadWidth-1-:2]);
    end
    side_q[0] <= {wave_scale, offset};
    for (int k = 1; k < CalcLatency - 1; k++) begin
      side_q[k] <= side_q[k-1];
    end
    phase <= dist_lo * side_scale + side_off;  // wraps modulo a full turn.
  end

  assign dist_lo    = root_q[SqrtStages-1][PhaseWidth-1:0];
  assign side_scale = side_q[CalcLatency-2][SideWidth-1-:ScaleWidth];
  assign side_off   = side_q[CalcLatency-2][PhaseWidth-1:0];

endmodule

// ==== src/sin_cos_lut.sv ====
`timescale 1ns/10ps
module sin_cos_lut (
  input  logic                                        CLK,
  input  logic       [phase_math_pkg::PhaseWidth-1:0] phase,
  output logic signed [phase_math_pkg::TrigWidth-1:0] sin,
  output logic signed [phase_math_pkg::TrigWidth-1:0] cos
);
  import phase_math_pkg::*;

  localparam int IdxWidth    = 6;
  localparam int QuarterSize = 1 << (IdxWidth - 2);

  // round(127 * sin(2*pi*k/64)) over the first quadrant.
  localparam logic [TrigWidth-2:0] QuarterTable [QuarterSize] = '{
    7'd0, 7'd12, 7'd25, 7'd37, 7'd49, 7'd60, 7'd71, 7'd81,
    7'd90, 7'd98, 7'd106, 7'd112, 7'd117, 7'd122, 7'd125, 7'd126
  };
  localparam logic [TrigWidth-1:0] PeakValue = 8'd127;

  logic [IdxWidth-1:0] idx;

  function automatic logic signed [TrigWidth-1:0] wave(input logic [IdxWidth-1:0] n);
    logic [IdxWidth-2:0] k;
    logic [TrigWidth-1:0] mag;
    if (n[IdxWidth-2]) begin
      k = (IdxWidth-1)'(QuarterSize) - n[IdxWidth-3:0];  // second half of each lobe mirrors.
    end else begin
      k = {1'b0, n[IdxWidth-3:0]};
    end
    mag = k[IdxWidth-2] ? PeakValue : {1'b0, QuarterTable[k[IdxWidth-3:0]]};
    return n[IdxWidth-1] ? -mag : mag;  // lower half of the turn is negative.
  endfunction

  assign idx = phase[PhaseWidth-1-:IdxWidth];

  always_ff @(posedge CLK) begin
    sin <= wave(idx);
    cos <= wave(idx + IdxWidth'(QuarterSize));  // cosine leads by a quarter turn.
  end

endmodule

// ==== src/phase_atan_cordic.sv ====
`timescale 1ns/10ps
module phase_atan_cordic (
  input  logic                                       CLK,
  input  logic signed [phase_math_pkg::SumWidth-1:0] sum_cos,
  input  logic signed [phase_math_pkg::SumWidth-1:0] sum_sin,
  output logic      [phase_math_pkg::PhaseWidth-1:0] phase
);
  import phase_math_pkg::*;

  localparam int Stages   = CordicLatency - 1;  // the first stage only folds the quadrant.
  localparam int FracBits = 3;
  localparam int XyWidth  = SumWidth + 2 + FracBits;  // room for the CORDIC gain.
  localparam int AngFrac  = 4;
  localparam int AngWidth = PhaseWidth + AngFrac;
  localparam int HalfTurn = 1 << (AngWidth - 1);
  localparam int HalfStep = 1 << (AngFrac - 1);

  // atan(2^-i) in 1/4096 of a turn.
  localparam logic [AngWidth-1:0] AtanTable [Stages] = '{
    12'd512, 12'd302, 12'd160, 12'd81, 12'd41, 12'd20, 12'd10, 12'd5
  };

  logic signed [XyWidth-1:0] x_in, y_in;
  logic signed [XyWidth-1:0] x_q [CordicLatency];
  logic signed [XyWidth-1:0] y_q [CordicLatency];
  logic       [AngWidth-1:0] ang_q [CordicLatency];

  assign x_in = XyWidth'(sum_cos) <<< FracBits;
  assign y_in = XyWidth'(sum_sin) <<< FracBits;

  always_ff @(posedge CLK) begin
    // half a step is preloaded so the final truncation rounds.
    if (x_in < 0) begin
      x_q[0]   <= -x_in;
      y_q[0]   <= -y_in;
      ang_q[0] <= AngWidth'(HalfTurn + HalfStep);
    end else begin
      x_q[0]   <= x_in;
      y_q[0]   <= y_in;
      ang_q[0] <= AngWidth'(HalfStep);
    end
    for (int i = 0; i < Stages; i++) begin
      if (y_q[i] < 0) begin
        x_q[i+1]   <= x_q[i] - (y_q[i] >>> i);
        y_q[i+1]   <= y_q[i] + (x_q[i] >>> i);
        ang_q[i+1] <= ang_q[i] - AtanTable[i];
      end else begin
        x_q[i+1]   <= x_q[i] + (y_q[i] >>> i);
        y_q[i+1]   <= y_q[i] - (x_q[i] >>> i);
        ang_q[i+1] <= ang_q[i] + AtanTable[i];
      end
    end
  end

  assign phase = ang_q[Stages][AngWidth-1-:PhaseWidth];

endmodule

// ==== src/focus_stm_engine.sv ====
`timescale 1ns/10ps
module focus_stm_engine (
  input  logic                                         CLK,
  input  logic                                         rst,
  input  logic                                         start,
  input  logic        [array_geom_pkg::PointWidth-1:0] stm_idx,
  input  logic          [array_geom_pkg::SlotWidth:0] num_foci,
  input  logic        [phase_math_pkg::ScaleWidth-1:0] wave_scale,
  output logic        [array_geom_pkg::PointWidth-1:0] rd_point,
  output logic        [ array_geom_pkg::SlotWidth-1:0] rd_slot,
  input  logic signed [array_geom_pkg::CoordWidth-1:0] rd_x,
  input  logic signed [array_geom_pkg::CoordWidth-1:0] rd_y,
  input  logic signed [array_geom_pkg::CoordWidth-1:0] rd_z,
  input  logic        [array_geom_pkg::LevelWidth-1:0] rd_level,
  input  logic                                         credit_return,
  output logic                                         busy,
  output logic                                         phase_valid,
  output logic        [array_geom_pkg::TransWidth-1:0] phase_trans,
  output logic        [phase_math_pkg::PhaseWidth-1:0] phase,
  output logic        [array_geom_pkg::LevelWidth-1:0] intensity
);
  import array_geom_pkg::*;
  import phase_math_pkg::*;

  localparam int PairWidth = TrigWidth + 1;

  typedef enum logic [1:0] {IDLE, LOAD, ISSUE, DRAIN} state_t;

  state_t                       state;
  logic         [SlotWidth:0]   load_cnt;
  logic         [SlotWidth-1:0] load_slot;
  logic        [TransWidth-1:0] trans_cnt;
  logic       [CreditWidth-1:0] credits;
  logic                         issue;
  logic        [PointWidth-1:0] point_q;
  logic         [SlotWidth:0]   nfoci_q;
  logic        [ScaleWidth-1:0] scale_q;
  logic signed [CoordWidth-1:0] focus_x [NumFociMax];
  logic signed [CoordWidth-1:0] focus_y [NumFociMax];
  logic signed [CoordWidth-1:0] focus_z [NumFociMax];
  logic        [LevelWidth-1:0] level_q [NumFociMax];
  logic signed [CoordWidth-1:0] trans_x, trans_y;
  logic       [PipeLatency-1:0] valid_sr;
  logic        [TransWidth-1:0] trans_sr [PipeLatency];
  logic        [PhaseWidth-1:0] calc_phase [NumFociMax];
  logic        [PhaseWidth-1:0] slot_offset [NumFociMax];
  logic signed  [TrigWidth-1:0] lut_sin [NumFociMax];
  logic signed  [TrigWidth-1:0] lut_cos [NumFociMax];
  logic signed  [TrigWidth-1:0] act_sin [NumFociMax];
  logic signed  [TrigWidth-1:0] act_cos [NumFociMax];
  logic signed  [PairWidth-1:0] pair_sin [NumFociMax/2];
  logic signed  [PairWidth-1:0] pair_cos [NumFociMax/2];
  logic signed   [SumWidth-1:0] sum_sin, sum_cos;

  assign busy      = (state != IDLE);
  assign rd_point  = point_q;
  assign rd_slot   = load_cnt[SlotWidth-1:0];
  assign load_slot = SlotWidth'(load_cnt - 1'b1);  // data lags the address by one cycle.
  assign intensity = level_q[0];
  // a credit returned in this cycle can be spent at once.
  assign issue = (state == ISSUE) && ((credits != '0) || credit_return);

  always_ff @(posedge CLK) begin
    if (rst) begin
      state     <= IDLE;
      load_cnt  <= '0;
      trans_cnt <= '0;
      credits   <= CreditWidth'(CreditMax);
    end else begin
      credits <= credits - CreditWidth'(issue) + CreditWidth'(credit_return);
      case (state)
        IDLE: begin
          if (start) begin
            load_cnt <= '0;
            state    <= LOAD;
          end
        end
        LOAD: begin
          load_cnt <= load_cnt + 1'b1;
          if (load_cnt == (SlotWidth+1)'(NumFociMax)) begin
            trans_cnt <= '0;
            state     <= ISSUE;
          end
        end
        ISSUE: begin
          if (issue) begin
            trans_cnt <= trans_cnt + 1'b1;
            if (trans_cnt == TransWidth'(NumTrans - 1)) state <= DRAIN;
          end
        end
        default: begin
          if (phase_valid && phase_trans == TransWidth'(NumTrans - 1)) state <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (state == IDLE && start) begin
      point_q <= stm_idx;
      nfoci_q <= num_foci;
      scale_q <= wave_scale;
    end
    if (state == LOAD && load_cnt != '0) begin
      focus_x[load_slot] <= rd_x;
      focus_y[load_slot] <= rd_y;
      focus_z[load_slot] <= rd_z;
      level_q[load_slot] <= rd_level;
    end
    trans_x <= CoordWidth'((trans_cnt % GridCols) * Pitch);
    trans_y <= CoordWidth'((trans_cnt / GridCols) * Pitch);
    trans_sr[0] <= trans_cnt;
    for (int s = 1; s < PipeLatency; s++) begin
      trans_sr[s] <= trans_sr[s-1];
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      valid_sr <= '0;
    end else begin
      valid_sr <= {valid_sr[PipeLatency-2:0], issue};
    end
  end

  assign phase_valid = valid_sr[PipeLatency-1];
  assign phase_trans = trans_sr[PipeLatency-1];

  for (genvar i = 0; i < NumFociMax; i++) begin : gen_focus
    assign slot_offset[i] = (i == 0) ? '0 : level_q[i];  // slot 0 is the phase reference.
    assign act_sin[i] = ((SlotWidth+1)'(i) < nfoci_q) ? lut_sin[i] : '0;
    assign act_cos[i] = ((SlotWidth+1)'(i) < nfoci_q) ? lut_cos[i] : '0;

    focus_phase_calc u_calc (
      .CLK       (CLK),
      .focus_x   (focus_x[i]),
      .focus_y   (focus_y[i]),
      .focus_z   (focus_z[i]),
      .trans_x   (trans_x),
      .trans_y   (trans_y),
      .wave_scale(scale_q),
      .offset    (slot_offset[i]),
      .phase     (calc_phase[i])
    );

    sin_cos_lut u_lut (
      .CLK  (CLK),
      .phase(calc_phase[i]),
      .sin  (lut_sin[i]),
      .cos  (lut_cos[i])
    );
  end

  always_ff @(posedge CLK) begin
    for (int p = 0; p < NumFociMax / 2; p++) begin
      pair_sin[p] <= PairWidth'(act_sin[2*p]) + PairWidth'(act_sin[2*p+1]);
      pair_cos[p] <= PairWidth'(act_cos[2*p]) + PairWidth'(act_cos[2*p+1]);
    end
    sum_sin <= SumWidth'(pair_sin[0]) + SumWidth'(pair_sin[1]);
    sum_cos <= SumWidth'(pair_cos[0]) + SumWidth'(pair_cos[1]);
  end

  phase_atan_cordic u_cordic (
    .CLK    (CLK),
    .sum_cos(sum_cos),
    .sum_sin(sum_sin),
    .phase  (phase)
  );

endmodule

// ==== src/focus_stm_top.sv ====
`timescale 1ns/10ps
module focus_stm_top (
  input  logic                                         CLK,
  input  logic                                         rst,
  input  logic                                         wr_en,
  input  logic        [array_geom_pkg::PointWidth-1:0] wr_point,
  input  logic        [ array_geom_pkg::SlotWidth-1:0] wr_slot,
  input  logic signed [array_geom_pkg::CoordWidth-1:0] wr_x,
  input  logic signed [array_geom_pkg::CoordWidth-1:0] wr_y,
  input  logic signed [array_geom_pkg::CoordWidth-1:0] wr_z,
  input  logic        [array_geom_pkg::LevelWidth-1:0] wr_level,
  input  logic                                         start,
  input  logic        [array_geom_pkg::PointWidth-1:0] stm_idx,
  input  logic          [array_geom_pkg::SlotWidth:0] num_foci,
  input  logic        [phase_math_pkg::ScaleWidth-1:0] wave_scale,
  input  logic                                         credit_return,
  output logic                                         busy,
  output logic                                         phase_valid,
  output logic        [array_geom_pkg::TransWidth-1:0] phase_trans,
  output logic        [phase_math_pkg::PhaseWidth-1:0] phase,
  output logic        [array_geom_pkg::LevelWidth-1:0] intensity
);
  import array_geom_pkg::*;

  logic        [PointWidth-1:0] rd_point;
  logic        [ SlotWidth-1:0] rd_slot;
  logic signed [CoordWidth-1:0] rd_x, rd_y, rd_z;
  logic        [LevelWidth-1:0] rd_level;

  focus_store u_store (
    .CLK     (CLK),
    .wr_en   (wr_en),
    .wr_point(wr_point),
    .wr_slot (wr_slot),
    .wr_x    (wr_x),
    .wr_y    (wr_y),
    .wr_z    (wr_z),
    .wr_level(wr_level),
    .rd_point(rd_point),
    .rd_slot (rd_slot),
    .rd_x    (rd_x),
    .rd_y    (rd_y),
    .rd_z    (rd_z),
    .rd_level(rd_level)
  );

  focus_stm_engine u_engine (
    .CLK          (CLK),
    .rst          (rst),
    .start        (start),
    .stm_idx      (stm_idx),
    .num_foci     (num_foci),
    .wave_scale   (wave_scale),
    .rd_point     (rd_point),
    .rd_slot      (rd_slot),
    .rd_x         (rd_x),
    .rd_y         (rd_y),
    .rd_z         (rd_z),
    .rd_level     (rd_level),
    .credit_return(credit_return),
    .busy         (busy),
    .phase_valid  (phase_valid),
    .phase_trans  (phase_trans),
    .phase        (phase),
    .intensity    (intensity)
  );

endmodule

// ==== verification/focus_stm_assertions.sv ====
`timescale 1ns/10ps
module focus_stm_assertions (
  input logic                                   CLK,
  input logic                                   rst,
  input logic                                   credit_return,
  input logic [phase_math_pkg::CreditWidth-1:0] credits,
  input logic [phase_math_pkg::PipeLatency-1:0] valid_sr,
  input logic                                   phase_valid,
  input logic  [array_geom_pkg::TransWidth-1:0] phase_trans
);
  import array_geom_pkg::*;
  import phase_math_pkg::*;

  logic [TransWidth-1:0] next_trans;  // index expected at the next output.

  always_ff @(posedge CLK) begin
    if (rst) begin
      next_trans <= '0;
    end else if (phase_valid) begin
      next_trans <= phase_trans + 1'b1;  // wraps to zero after the last transducer.
    end
  end

  credit_limit: assert property (@(posedge CLK) disable iff (rst)
    credits <= CreditWidth'(CreditMax))
    else $error("credit counter is above its limit");

  credit_balance: assert property (@(posedge CLK) disable iff (rst)
    $countones(valid_sr) + int'(credits) <= CreditMax + int'(credit_return))
    else $error("items in flight and credits exceed the receiver space");

  trans_order: assert property (@(posedge CLK) disable iff (rst)
    phase_valid |-> phase_trans == next_trans)
    else $error("output transducer index is out of order");

  quiet_after_reset: assert property (@(posedge CLK) rst |=> !phase_valid)
    else $error("phase_valid is high right after reset");

endmodule

bind focus_stm_engine focus_stm_assertions u_assertions (
  .CLK          (CLK),
  .rst          (rst),
  .credit_return(credit_return),
  .credits      (credits),
  .valid_sr     (valid_sr),
  .phase_valid  (phase_valid),
  .phase_trans  (phase_trans)
);

// ==== verification/focus_stm_tb.sv ====
`timescale 1ns/10ps
module focus_stm_tb;
  import array_geom_pkg::*;
  import phase_math_pkg::*;

  localparam int  TimeoutCycles = 6 * (PipeLatency + NumTrans + 8) * 20;
  localparam int  FullTurn      = 1 << PhaseWidth;
  localparam int  PhaseTol      = 2;
  localparam real TwoPi         = 6.283185307179586;

  logic                         CLK, rst, wr_en, start, credit_return, busy, phase_valid;
  logic        [PointWidth-1:0] wr_point, stm_idx;
  logic         [SlotWidth-1:0] wr_slot;
  logic signed [CoordWidth-1:0] wr_x, wr_y, wr_z;
  logic        [LevelWidth-1:0] wr_level, intensity;
  logic           [SlotWidth:0] num_foci;
  logic        [ScaleWidth-1:0] wave_scale;
  logic        [TransWidth-1:0] phase_trans;
  logic        [PhaseWidth-1:0] phase;

  int fx [NumPoints][NumFociMax];  // the testbench's own copy of what the store holds.
  int fy [NumPoints][NumFociMax];
  int fz [NumPoints][NumFociMax];
  int flevel [NumPoints][NumFociMax];
  int owed;  // outputs taken by the receiver and not yet credited back.
  int cycles;
  logic random_credits;
  integer seed;

  focus_stm_top u_dut (.*);

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= TimeoutCycles) begin
      report_failure($sformatf("Timeout: the runs did not finish within %0d cycles", cycles));
    end
  end

  // receiver model. It takes every output and pays one credit back per output.
  always @(posedge CLK) begin
    int held;
    logic give;
    held = owed + int'(phase_valid);
    if (held > CreditMax) begin
      report_failure("The receiver holds more outputs than it has credits for");
    end
    if (random_credits) begin
      give = (held > 0) && (($random(seed) & 1) != 0);
    end else begin
      give = phase_valid;
    end
    if (rst) begin
      credit_return <= 1'b0;
      owed          <= 0;
    end else begin
      credit_return <= give;
      owed          <= held - int'(give);
    end
  end

  function automatic int isqrt(input longint v);
    int r;
    r = 0;
    while (longint'(r + 1) * longint'(r + 1) <= v) begin
      r++;
    end
    return r;
  endfunction

  function automatic int trig_sample(input int idx);
    real r;
    r = 127.0 * $sin(TwoPi * idx / 64.0);
    return (r < 0.0) ? -$rtoi(0.5 - r) : $rtoi(r + 0.5);
  endfunction

  function automatic logic [PhaseWidth-1:0] model_phase(input int pt, input int nf,
                                                        input int scale, input int tr);
    longint dx, dy, dz;
    int ph, k;
    real s_sum, c_sum, ang;
    s_sum = 0.0;
    c_sum = 0.0;
    for (int s = 0; s < nf; s++) begin
      dx = fx[pt][s] - (tr % GridCols) * Pitch;
      dy = fy[pt][s] - (tr / GridCols) * Pitch;
      dz = fz[pt][s];
      ph = (isqrt(dx * dx + dy * dy + dz * dz) * scale + ((s == 0) ? 0 : flevel[pt][s]))
           % FullTurn;
      k = ph / 4;  // the table has 64 steps per turn.
      s_sum += trig_sample(k);
      c_sum += trig_sample((k + 16) % 64);
    end
    ang = $atan2(s_sum, c_sum) * FullTurn / TwoPi;
    if (ang < 0.0) begin
      ang += FullTurn;
    end
    return PhaseWidth'($rtoi(ang + 0.5));
  endfunction

  task automatic check_phase(input logic [PhaseWidth-1:0] got, input logic [PhaseWidth-1:0] exp,
                             input int tr);
    logic [PhaseWidth-1:0] diff;
    diff = got - exp;  // distance around the circle.
    if (diff > PhaseTol && diff < FullTurn - PhaseTol) begin
      report_failure($sformatf("Error at %0d ns: phase of transducer %0d is %0d, expected %0d",
                               $time, tr, got, exp));
    end
  endtask

  task automatic check_trans(input logic [TransWidth-1:0] got_tr,
                             input logic [TransWidth-1:0] exp_tr,
                             input logic [LevelWidth-1:0] got_lvl,
                             input logic [LevelWidth-1:0] exp_lvl);
    if (got_tr !== exp_tr || got_lvl !== exp_lvl) begin
      report_failure($sformatf(
          "Error at %0d ns: transducer %0d intensity %0d, expected %0d and %0d",
          $time, got_tr, got_lvl, exp_tr, exp_lvl));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      report_failure($sformatf("Error at %0d ns: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  task automatic write_focus(input int pt, input int sl, input int x, input int y, input int z,
                             input int lvl);
    fx[pt][sl]     = x;
    fy[pt][sl]     = y;
    fz[pt][sl]     = z;
    flevel[pt][sl] = lvl;
    @(posedge CLK);
    wr_en    <= 1'b1;
    wr_point <= PointWidth'(pt);
    wr_slot  <= SlotWidth'(sl);
    wr_x     <= CoordWidth'(x);
    wr_y     <= CoordWidth'(y);
    wr_z     <= CoordWidth'(z);
    wr_level <= LevelWidth'(lvl);
    @(posedge CLK);
    wr_en <= 1'b0;
  endtask

  task automatic start_pulse(input int pt, input int nf, input int scale);
    @(posedge CLK);
    start      <= 1'b1;
    stm_idx    <= PointWidth'(pt);
    num_foci   <= (SlotWidth+1)'(nf);
    wave_scale <= ScaleWidth'(scale);
    @(posedge CLK);
    start <= 1'b0;
  endtask

  task automatic collect_run(input int pt, input int nf, input int scale);
    int seen;
    seen = 0;
    while (seen < NumTrans) begin
      @(posedge CLK);
      if (phase_valid) begin
        check_trans(phase_trans, TransWidth'(seen), intensity, LevelWidth'(flevel[pt][0]));
        check_phase(phase, model_phase(pt, nf, scale, seen), seen);
        seen++;
      end
    end
    @(posedge CLK);
    check_flag(busy, 1'b0, "busy after the last output");
    check_flag(phase_valid, 1'b0, "phase_valid after the last output");
  endtask

  task automatic run_point(input int pt, input int nf, input int scale);
    start_pulse(pt, nf, scale);
    collect_run(pt, nf, scale);
  endtask

  task automatic expect_idle(input int n);
    repeat (n) begin
      @(posedge CLK);
      check_flag(busy, 1'b0, "busy while idle");
      check_flag(phase_valid, 1'b0, "phase_valid while idle");
    end
  endtask

  task automatic test_reset_idle();
    expect_idle(PipeLatency + NumTrans);
  endtask

  task automatic test_single_focus();
    write_focus(0, 0, 15, 5, 40, 200);
    run_point(0, 1, 17);
  endtask

  task automatic test_three_foci();
    write_focus(1, 0, 0, 0, 60, 90);
    write_focus(1, 1, 30, 10, 50, 64);
    write_focus(1, 2, -20, 25, 35, 150);
    write_focus(1, 3, 100, -100, 20, 33);  // beyond num_foci, so it must not count.
    run_point(1, 3, 9);
  endtask

  task automatic test_random_credits();
    write_focus(2, 0, -12, 18, 70, 45);
    write_focus(2, 1, 40, 30, 25, 200);
    @(posedge CLK);
    random_credits <= 1'b1;
    run_point(2, 2, 23);
    while (owed != 0) begin
      @(posedge CLK);
    end
    random_credits <= 1'b0;
  endtask

  task automatic test_two_points();
    write_focus(3, 0, 5, 12, 33, 77);
    write_focus(4, 0, 25, -8, 48, 130);
    write_focus(4, 1, -30, 40, 22, 10);
    start_pulse(3, 1, 13);
    repeat (8) @(posedge CLK);
    check_flag(busy, 1'b1, "busy during a run");
    start_pulse(4, 2, 5);  // lands in the middle of the run and is ignored.
    collect_run(3, 1, 13);
    expect_idle(4);
    run_point(4, 2, 5);
  endtask

  task automatic test_two_scales();
    run_point(1, 2, 17);
    run_point(1, 2, 41);
  endtask

  initial begin
    seed           = 32'hd7d8_6d00;
    rst            = 1'b1;
    wr_en          = 1'b0;
    wr_point       = '0;
    wr_slot        = '0;
    wr_x           = '0;
    wr_y           = '0;
    wr_z           = '0;
    wr_level       = '0;
    start          = 1'b0;
    stm_idx        = '0;
    num_foci       = '0;
    wave_scale     = '0;
    credit_return  = 1'b0;
    random_credits = 1'b0;
    owed           = 0;
    cycles         = 0;
    repeat (2) @(posedge CLK);
    rst <= 1'b0;
    test_reset_idle();
    test_single_focus();
    test_three_foci();
    test_random_credits();
    test_two_points();
    test_two_scales();
    $display("Test completed successfully");
    $finish;
  end

endmodule

// ==== tb.f ====
src/array_geom_pkg.sv
src/phase_math_pkg.sv
src/focus_store.sv
src/focus_phase_calc.sv
src/sin_cos_lut.sv
src/phase_atan_cordic.sv
src/focus_stm_engine.sv
src/focus_stm_top.sv
verification/focus_stm_assertions.sv
verification/focus_stm_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= focus_stm_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
